// ==== rtl/lsu_pkg.sv ====
package lsu_pkg;

	// ------------------------------
	// widths
	// ------------------------------
	typedef logic [31:0] lsu_addr_t;
	typedef logic [31:0] lsu_word_t;
	typedef logic [63:0] bus_data_t;
	typedef logic [7:0]  bus_strb_t;
	typedef logic [4:0]  reg_idx_t;
	typedef logic [3:0]  axi_id_t;
	typedef logic [2:0]  axi_size_t;

	localparam axi_size_t SIZE_BYTE = 3'd0;
	localparam axi_size_t SIZE_WORD = 3'd2;

	// serial port window, accessed one byte per beat
	localparam lsu_addr_t UART_BASE = 32'h1000_0000;
	localparam lsu_addr_t UART_LAST = 32'h1000_0fff;

	// ------------------------------
	// operations and FSM states
	// ------------------------------
	typedef enum logic [3:0] {
		OP_NONE,
		OP_LW,
		OP_LH,
		OP_LHU,
		OP_LB,
		OP_LBU,
		OP_SW,
		OP_SH,
		OP_SB
	} mem_op_t;

	typedef enum logic [1:0] {
		R_IDLE,
		R_ADDR,
		R_DATA,
		R_SECOND
	} read_state_t;

	typedef enum logic [2:0] {
		W_IDLE,
		W_ADDR,
		W_DATA,
		W_RESP,
		W_SECOND
	} write_state_t;

	// ------------------------------
	// bundles
	// ------------------------------
	typedef struct packed {
		mem_op_t   op;
		lsu_addr_t addr;
		lsu_word_t data;
		reg_idx_t  rd;
	} mem_req_t;

	// shared by ar and aw
	typedef struct packed {
		lsu_addr_t addr;
		axi_id_t   id;
		axi_size_t size;
	} addr_req_t;

	typedef struct packed {
		bus_data_t data;
		bus_strb_t strb;
	} w_beat_t;

	typedef struct packed {
		bus_data_t data;
		axi_id_t   id;
	} r_beat_t;

	typedef struct packed {
		logic      need_second;
		lsu_addr_t first_addr;
		lsu_addr_t second_addr;
		bus_strb_t first_strb;
		bus_strb_t second_strb;
		bus_data_t wdata;
		axi_size_t size;
	} split_t;

	function automatic logic is_load_op(mem_op_t op);
		return op inside {OP_LW, OP_LH, OP_LHU, OP_LB, OP_LBU};
	endfunction

	function automatic logic is_store_op(mem_op_t op);
		return op inside {OP_SW, OP_SH, OP_SB};
	endfunction

endpackage

// ==== rtl/lsu_stage.sv ====
`timescale 1ns/1ns

module lsu_stage import lsu_pkg::*; (
	input  logic      clock,
	input  logic      reset,
	input  mem_req_t  req,
	input  logic      req_valid,
	output logic      req_allowin,
	input  logic      finished,
	output mem_req_t  held,
	output logic      stage_valid,
	output axi_id_t   txn_id,
	input  lsu_word_t load_value,
	output logic      done,
	output logic      wb_en,
	output reg_idx_t  wb_rd,
	output lsu_word_t wb_data
);

	// stage can take a new request while the old one retires
	assign req_allowin = !stage_valid || finished;

	always_ff @(posedge clock) begin
		if (reset) begin
			stage_valid <= 1'b0;
		end else if (req_allowin) begin
			stage_valid <= req_valid;
		end
	end

	always_ff @(posedge clock) begin
		if (req_allowin && req_valid) begin
			held <= req;
		end
	end

	// free-running ID source, channels sample it when they start
	always_ff @(posedge clock) begin
		if (reset) begin
			txn_id <= '0;
		end else if (txn_id == 4'hf) begin
			txn_id <= '0;
		end else begin
			txn_id <= txn_id + 4'd1;
		end
	end

	// ------------------------------
	// retire
	// ------------------------------
	assign done    = stage_valid && finished;
	assign wb_en   = done && is_load_op(held.op);
	assign wb_rd   = held.rd;
	assign wb_data = load_value;

endmodule

// ==== rtl/access_split.sv ====
`timescale 1ns/1ns

module access_split import lsu_pkg::*; (
	input  mem_req_t held,
	output split_t   plan
);

	logic [3:0]  width_mask;
	logic        is_word;
	logic        is_half;
	logic [11:0] shifted;
	bus_strb_t   lanes;
	bus_strb_t   word_lanes;
	bus_data_t   wdata;

	// byte count of the access, as a mask from the low byte
	always_comb begin
		is_word = 1'b0;
		is_half = 1'b0;
		case (held.op)
			OP_LW, OP_SW: begin
				width_mask = 4'b1111;
				is_word    = 1'b1;
			end
			OP_LH, OP_LHU, OP_SH: begin
				width_mask = 4'b0011;
				is_half    = 1'b1;
			end
			OP_LB, OP_LBU, OP_SB: begin
				width_mask = 4'b0001;
			end
			default: begin
				width_mask = 4'b0000;
			end
		endcase
	end

	// ------------------------------
	// strobes
	// ------------------------------
	// lanes past bit 7 wrap into the next doubleword
	assign shifted    = {8'h00, width_mask} << held.addr[2:0];
	assign lanes      = shifted[7:0] | {4'b0000, shifted[11:8]};
	assign word_lanes = held.addr[2] ? 8'hf0 : 8'h0f;

	// byte i of store data sits on lane (addr + i) mod 8
	always_comb begin
		logic [2:0] lane;
		wdata = '0;
		for (int i = 0; i < 4; i++) begin
			lane = held.addr[2:0] + 3'(i);
			wdata[lane*8 +: 8] = held.data[i*8 +: 8];
		end
	end

	always_comb begin
		plan.need_second = (is_word && held.addr[1:0] != 2'd0)
			|| (is_half && held.addr[1:0] == 2'd3);
		plan.first_addr  = held.addr;
		// next aligned word
		plan.second_addr = {held.addr[31:2] + 30'd1, 2'b00};
		plan.first_strb  = lanes & word_lanes;
		plan.second_strb = lanes & ~word_lanes;
		plan.wdata       = wdata;
		if (held.addr >= UART_BASE && held.addr <= UART_LAST) begin
			plan.size = SIZE_BYTE;
		end else begin
			plan.size = SIZE_WORD;
		end
	end

endmodule

// ==== rtl/read_channel.sv ====
`timescale 1ns/1ns

module read_channel import lsu_pkg::*; (
	input  logic      clock,
	input  logic      reset,
	input  logic      start,
	input  logic      need_second,
	input  lsu_addr_t first_addr,
	input  lsu_addr_t second_addr,
	input  axi_size_t size,
	input  axi_id_t   txn_id,
	output addr_req_t ar,
	output logic      arvalid,
	input  logic      arready,
	input  r_beat_t   r,
	input  logic      rvalid,
	output logic      rready,
	output logic      finished,
	output bus_data_t first_beat,
	output bus_data_t last_beat
);

	read_state_t state;
	read_state_t state_next;
	logic        second_q;
	axi_id_t     id_q;
	bus_data_t   first_q;
	logic        beat_taken;
	logic        last;

	// beats with a foreign ID are left alone
	assign beat_taken = rvalid && rready && (r.id == id_q);
	assign last       = second_q || !need_second;

	always_comb begin
		state_next = state;
		case (state)
			R_IDLE: begin
				if (start) begin
					state_next = R_ADDR;
				end
			end
			R_ADDR, R_SECOND: begin
				if (arready) begin
					state_next = R_DATA;
				end
			end
			R_DATA: begin
				if (beat_taken) begin
					state_next = last ? R_IDLE : R_SECOND;
				end
			end
			default: state_next = R_IDLE;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state    <= R_IDLE;
			second_q <= 1'b0;
		end else begin
			state <= state_next;
			if (state_next == R_SECOND) begin
				second_q <= 1'b1;
			end else if (state_next == R_IDLE) begin
				second_q <= 1'b0;
			end
		end
	end

	// one ID for both beats of a split load
	always_ff @(posedge clock) begin
		if (state == R_IDLE && start) begin
			id_q <= txn_id;
		end
		if (beat_taken && !last) begin
			first_q <= r.data;
		end
	end

	assign ar = '{addr: second_q ? second_addr : first_addr, id: id_q, size: size};

	assign arvalid    = (state == R_ADDR) || (state == R_SECOND);
	assign rready     = (state == R_DATA);
	assign finished   = beat_taken && last;
	assign first_beat = need_second ? first_q : r.data;
	assign last_beat  = r.data;

endmodule

// ==== rtl/write_channel.sv ====
`timescale 1ns/1ns

module write_channel import lsu_pkg::*; (
	input  logic         clock,
	input  logic         reset,
	input  logic         start,
	input  logic         need_second,
	input  lsu_addr_t    first_addr,
	input  lsu_addr_t    second_addr,
	input  bus_strb_t    first_strb,
	input  bus_strb_t    second_strb,
	input  bus_data_t    wdata,
	input  axi_size_t    size,
	input  axi_id_t      txn_id,
	output addr_req_t    aw,
	output logic         awvalid,
	input  logic         awready,
	output w_beat_t      w,
	output logic         wvalid,
	input  logic         wready,
	input  axi_id_t      bid,
	input  logic         bvalid,
	output logic         bready
	,
	output logic         finished
);

	write_state_t state;
	write_state_t state_next;
	logic         second_q;
	axi_id_t      id_q;
	logic         resp_taken;
	logic         last;

	assign resp_taken = bvalid && bready && (bid == id_q);
	assign last       = second_q || !need_second;

	// ------------------------------
	// aw, then w, then b per beat
	// ------------------------------
	always_comb begin
		state_next = state;
		case (state)
			W_IDLE: begin
				if (start) begin
					state_next = W_ADDR;
				end
			end
			W_ADDR, W_SECOND: begin
				if (awready) begin
					state_next = W_DATA;
				end
			end
			W_DATA: begin
				if (wready) begin
					state_next = W_RESP;
				end
			end
			W_RESP: begin
				if (resp_taken) begin
					state_next = last ? W_IDLE : W_SECOND;
				end
			end
			default: state_next = W_IDLE;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state    <= W_IDLE;
			second_q <= 1'b0;
		end else begin
			state <= state_next;
			if (state_next == W_SECOND) begin
				second_q <= 1'b1;
			end else if (state_next == W_IDLE) begin
				second_q <= 1'b0;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (state == W_IDLE && start) begin
			id_q <= txn_id;
		end
	end

	assign aw = '{addr: second_q ? second_addr : first_addr, id: id_q, size: size};

	// data is already lane-rotated, the strobe picks the beat's bytes
	assign w = '{data: wdata, strb: second_q ? second_strb : first_strb};

	assign awvalid  = (state == W_ADDR) || (state == W_SECOND);
	assign wvalid   = (state == W_DATA);
	assign bready   = (state == W_RESP);
	assign finished = resp_taken && last;

endmodule

// ==== rtl/load_merge.sv ====
`timescale 1ns/1ns

module load_merge import lsu_pkg::*; (
	input  mem_op_t   op,
	input  lsu_addr_t addr,
	input  bus_strb_t first_strb,
	input  bus_strb_t second_strb,
	input  bus_data_t first_beat,
	input  bus_data_t last_beat,
	output lsu_word_t value
);

	logic [3:0][7:0] merged;

	// byte k of the result comes from lane (addr + k) mod 8
	always_comb begin
		logic [2:0] lane;
		merged = '0;
		for (int k = 0; k < 4; k++) begin
			lane = addr[2:0] + 3'(k);
			if (first_strb[lane]) begin
				merged[k] = first_beat[lane*8 +: 8];
			end else if (second_strb[lane]) begin
				merged[k] = last_beat[lane*8 +: 8];
			end
		end
	end

	// sign or zero extension
	always_comb begin
		case (op)
			OP_LW:   value = merged;
			OP_LH:   value = {{16{merged[1][7]}}, merged[1], merged[0]};
			OP_LHU:  value = {16'h0000, merged[1], merged[0]};
			OP_LB:   value = {{24{merged[0][7]}}, merged[0]};
			OP_LBU:  value = {24'h000000, merged[0]};
			default: value = '0;
		endcase
	end

endmodule

// ==== rtl/lsu_top.sv ====
`timescale 1ns/1ns

module lsu_top import lsu_pkg::*; (
	input  logic      clock,
	input  logic      reset,
	input  mem_req_t  req,
	input  logic      req_valid,
	output logic      req_allowin,
	output logic      done,
	output logic      wb_en,
	output reg_idx_t  wb_rd,
	output lsu_word_t wb_data,
	output addr_req_t ar,
	output logic      arvalid,
	input  logic      arready,
	input  r_beat_t   r,
	input  logic      rvalid,
	output logic      rready,
	output addr_req_t aw,
	output logic      awvalid,
	input  logic      awready,
	output w_beat_t   w,
	output logic      wvalid,
	input  logic      wready,
	input  axi_id_t   bid,
	input  logic      bvalid,
	output logic      bready
);

	mem_req_t  held;
	logic      stage_valid;
	axi_id_t   txn_id;
	split_t    split;
	logic      is_load;
	logic      is_store;
	logic      rd_finished;
	logic      wr_finished;
	logic      finished;
	bus_data_t first_beat;
	bus_data_t last_beat;
	lsu_word_t load_value;

	assign is_load  = is_load_op(held.op);
	assign is_store = is_store_op(held.op);

	// OP_NONE has no bus work and retires at once
	assign finished = is_load ? rd_finished : (is_store ? wr_finished : 1'b1);

	lsu_stage i_lsu_stage (
		.clock       (clock),
		.reset       (reset),
		.req         (req),
		.req_valid   (req_valid),
		.req_allowin (req_allowin),
		.finished    (finished),
		.held        (held),
		.stage_valid (stage_valid),
		.txn_id      (txn_id),
		.load_value  (load_value),
		.done        (done),
		.wb_en       (wb_en),
		.wb_rd       (wb_rd),
		.wb_data     (wb_data)
	);

	access_split i_access_split (
		.held (held),
		.plan (split)
	);

	read_channel i_read_channel (
		.clock       (clock),
		.reset       (reset),
		.start       (stage_valid && is_load),
		.need_second (split.need_second),
		.first_addr  (split.first_addr),
		.second_addr (split.second_addr),
		.size        (split.size),
		.txn_id      (txn_id),
		.ar          (ar),
		.arvalid     (arvalid),
		.arready     (arready),
		.r           (r),
		.rvalid      (rvalid),
		.rready      (rready),
		.finished    (rd_finished),
		.first_beat  (first_beat),
		.last_beat   (last_beat)
	);

	write_channel i_write_channel (
		.clock       (clock),
		.reset       (reset),
		.start       (stage_valid && is_store),
		.need_second (split.need_second),
		.first_addr  (split.first_addr),
		.second_addr (split.second_addr),
		.first_strb  (split.first_strb),
		.second_strb (split.second_strb),
		.wdata       (split.wdata),
		.size        (split.size),
		.txn_id      (txn_id),
		.aw          (aw),
		.awvalid     (awvalid),
		.awready     (awready),
		.w           (w),
		.wvalid      (wvalid),
		.wready      (wready),
		.bid         (bid),
		.bvalid      (bvalid),
		.bready      (bready),
		.finished    (wr_finished)
	);

	load_merge i_load_merge (
		.op          (held.op),
		.addr        (held.addr),
		.first_strb  (split.first_strb),
		.second_strb (split.second_strb),
		.first_beat  (first_beat),
		.last_beat   (last_beat),
		.value       (load_value)
	);

endmodule

// ==== bench/lsu_properties.sv ====
`timescale 1ns/1ns

module lsu_properties import lsu_pkg::*; (
	input logic      clock,
	input logic      reset,
	input addr_req_t ar,
	input logic      arvalid,
	input logic      arready,
	input addr_req_t aw,
	input logic      awvalid,
	input logic      awready,
	input logic      wvalid,
	input logic      wready,
	input logic      done
);

	// ------------------------------
	// valids wait for their ready
	// ------------------------------
	ar_held: assert property (@(posedge clock) disable iff (reset)
		arvalid && !arready |=> arvalid && $stable(ar))
		else $error("arvalid dropped or ar changed before its transfer");

	aw_held: assert property (@(posedge clock) disable iff (reset)
		awvalid && !awready |=> awvalid && $stable(aw))
		else $error("awvalid dropped or aw changed before its transfer");

	w_held: assert property (@(posedge clock) disable iff (reset)
		wvalid && !wready |=> wvalid)
		else $error("wvalid dropped before its transfer");

	// one request at a time in the bench, so done never repeats
	done_pulse: assert property (@(posedge clock) disable iff (reset)
		done |=> !done)
		else $error("done held for more than one cycle");

endmodule

bind lsu_top lsu_properties i_lsu_properties (
	.clock   (clock),
	.reset   (reset),
	.ar      (ar),
	.arvalid (arvalid),
	.arready (arready),
	.aw      (aw),
	.awvalid (awvalid),
	.awready (awready),
	.wvalid  (wvalid),
	.wready  (wready),
	.done    (done)
);

// ==== bench/lsu_tb.sv ====
`timescale 1ns/1ns

module lsu_tb import lsu_pkg::*; ();

	logic      clock;
	logic      reset;
	mem_req_t  req;
	logic      req_valid;
	logic      req_allowin;
	logic      done;
	logic      wb_en;
	reg_idx_t  wb_rd;
	lsu_word_t wb_data;
	addr_req_t ar;
	logic      arvalid;
	logic      arready;
	r_beat_t   r;
	logic      rvalid;
	logic      rready;
	addr_req_t aw;
	logic      awvalid;
	logic      awready;
	w_beat_t   w;
	logic      wvalid;
	logic      wready;
	axi_id_t   bid;
	logic      bvalid;
	logic      bready;

	// one entry per line of the tests file
	string     test_name[$];
	mem_op_t   test_op[$];
	lsu_addr_t test_addr[$];
	lsu_word_t test_data[$];
	reg_idx_t  test_rd[$];
	lsu_word_t test_expect[$];
	int        cur;

	// memory model state
	logic [7:0] mem [lsu_addr_t];
	logic       rd_pending;
	lsu_addr_t  rd_addr;
	axi_id_t    rd_id;
	lsu_addr_t  wr_addr;
	axi_id_t    wr_id;
	logic       b_pending;

	int        ar_count;
	int        aw_count;
	int        w_count;
	int        taken_count;
	int        done_count;
	int        wb_count;
	reg_idx_t  last_rd;
	lsu_word_t last_wb;
	int        cycles;
	int        cycle_limit;

	lsu_top i_lsu_top (.*);

	always #20 clock = ~clock;

	task automatic fail_now(input string why);
		$display("%s", why);
		$display("Test failures found");
		$fatal(1, "run stopped at first failure");
	endtask

	task automatic check_word(input string test, input string what,
		input lsu_word_t expected, input lsu_word_t actual);
		if (actual !== expected) begin
			fail_now($sformatf("Error %s %s: expected %h, actual %h",
				test, what, expected, actual));
		end
	endtask

	task automatic check_size(input string test, input string what,
		input axi_size_t expected, input axi_size_t actual);
		if (actual !== expected) begin
			fail_now($sformatf("Error %s %s: expected %0d, actual %0d",
				test, what, expected, actual));
		end
	endtask

	task automatic check_reg(input string test, input string what,
		input reg_idx_t expected, input reg_idx_t actual);
		if (actual !== expected) begin
			fail_now($sformatf("Error %s %s: expected %0d, actual %0d",
				test, what, expected, actual));
		end
	endtask

	task automatic check_count(input string test, input string what,
		input int expected, input int actual);
		if (actual != expected) begin
			fail_now($sformatf("Error %s %s: expected %0d, actual %0d",
				test, what, expected, actual));
		end
	endtask

	// ------------------------------
	// rules for expected bus shape
	// ------------------------------
	function automatic int beats_by_rule(mem_op_t op, lsu_addr_t addr);
		case (op)
			OP_LW, OP_SW: return (addr[2:0] == 3'd0 || addr[2:0] == 3'd4) ? 1 : 2;
			OP_LH, OP_LHU, OP_SH: return (addr[2:0] == 3'd3 || addr[2:0] == 3'd7) ? 2 : 1;
			OP_NONE: return 0;
			default: return 1;
		endcase
	endfunction

	function automatic axi_size_t size_by_rule(lsu_addr_t addr);
		return (addr >= UART_BASE && addr <= UART_LAST) ? SIZE_BYTE : SIZE_WORD;
	endfunction

	// unwritten bytes read back as a mix of every address byte
	function automatic logic [7:0] fill_byte(lsu_addr_t a);
		return a[31:24] ^ a[23:16] ^ a[15:8] ^ a[7:0] ^ 8'ha5;
	endfunction

	function automatic bus_data_t read_dword(lsu_addr_t a);
		bus_data_t d;
		lsu_addr_t b;
		for (int j = 0; j < 8; j++) begin
			b = {a[31:3], 3'(j)};
			d[j*8 +: 8] = mem.exists(b) ? mem[b] : fill_byte(b);
		end
		return d;
	endfunction

	task automatic write_lanes(input lsu_addr_t a, input bus_data_t d, input bus_strb_t s);
		for (int j = 0; j < 8; j++) begin
			if (s[j]) begin
				mem[{a[31:3], 3'(j)}] = d[j*8 +: 8];
			end
		end
	endtask

	task automatic decode_op(input string text, output mem_op_t op);
		case (text)
			"lw":    op = OP_LW;
			"lh":    op = OP_LH;
			"lhu":   op = OP_LHU;
			"lb":    op = OP_LB;
			"lbu":   op = OP_LBU;
			"sw":    op = OP_SW;
			"sh":    op = OP_SH;
			"sb":    op = OP_SB;
			"none":  op = OP_NONE;
			default: begin
				op = OP_NONE;
				fail_now($sformatf("unknown operation %s in the tests file", text));
			end
		endcase
	endtask

	task automatic load_tests();
		int        fd;
		int        n;
		string     line;
		string     name;
		string     op_text;
		mem_op_t   op;
		lsu_addr_t addr;
		lsu_word_t data;
		reg_idx_t  rd;
		lsu_word_t expect_v;
		fd = $fopen("bench/lsu_tests.txt", "r");
		if (fd == 0) begin
			fail_now("cannot open bench/lsu_tests.txt");
		end
		while ($fgets(line, fd) > 0) begin
			if (line.len() > 1 && line.substr(0, 0) != "#") begin
				n = $sscanf(line, "%s %s %h %h %h %h",
					name, op_text, addr, data, rd, expect_v);
				if (n != 6) begin
					fail_now($sformatf("malformed line in the tests file: %s", line));
				end
				decode_op(op_text, op);
				test_name.push_back(name);
				test_op.push_back(op);
				test_addr.push_back(addr);
				test_data.push_back(data);
				test_rd.push_back(rd);
				test_expect.push_back(expect_v);
			end
		end
		$fclose(fd);
	endtask

	// ------------------------------
	// bus monitor and memory update
	// ------------------------------
	always @(posedge clock) begin
		if (!reset) begin
			if (req_valid && req_allowin) begin
				taken_count++;
			end
			if (arvalid && arready) begin
				check_size(test_name[cur], "ar size",
					size_by_rule(test_addr[cur]), ar.size);
				rd_addr = ar.addr;
				rd_id = ar.id;
				rd_pending = 1'b1;
				ar_count++;
			end
			if (rvalid && rready) begin
				rd_pending = 1'b0;
			end
			if (awvalid && awready) begin
				check_size(test_name[cur], "aw size",
					size_by_rule(test_addr[cur]), aw.size);
				wr_addr = aw.addr;
				wr_id = aw.id;
				aw_count++;
			end
			if (wvalid && wready) begin
				write_lanes(wr_addr, w.data, w.strb);
				b_pending = 1'b1;
				w_count++;
			end
			if (bvalid && bready) begin
				b_pending = 1'b0;
			end
			if (done) begin
				done_count++;
			end
			if (wb_en) begin
				last_rd = wb_rd;
				last_wb = wb_data;
				wb_count++;
			end
		end
	end

	always @(posedge clock) begin
		cycles++;
		if (cycles > cycle_limit) begin
			fail_now($sformatf("timeout after %0d cycles with no end of the test run",
				cycles));
		end
	end

	// random ready and response delays, responses hold until taken
	always @(negedge clock) begin
		if (!reset) begin
			arready = ($urandom % 3) != 0;
			awready = ($urandom % 3) != 0;
			wready = ($urandom % 3) != 0;
			if (!rd_pending) begin
				rvalid = 1'b0;
			end else if (!rvalid) begin
				rvalid = ($urandom % 2) == 0;
			end
			r.data = read_dword(rd_addr);
			r.id = rd_id;
			if (!b_pending) begin
				bvalid = 1'b0;
			end else if (!bvalid) begin
				bvalid = ($urandom % 2) == 0;
			end
			bid = wr_id;
		end
	end

	task automatic run_test(input int i);
		int        ar_base;
		int        aw_base;
		int        w_base;
		int        taken_base;
		int        done_base;
		int        wb_base;
		int        beats;
		logic      is_load;
		logic      is_store;
		cur = i;
		ar_base = ar_count;
		aw_base = aw_count;
		w_base = w_count;
		taken_base = taken_count;
		done_base = done_count;
		wb_base = wb_count;
		beats = beats_by_rule(test_op[i], test_addr[i]);
		is_load = test_op[i] inside {OP_LW, OP_LH, OP_LHU, OP_LB, OP_LBU};
		is_store = test_op[i] inside {OP_SW, OP_SH, OP_SB};
		req = '{op: test_op[i], addr: test_addr[i], data: test_data[i], rd: test_rd[i]};
		req_valid = 1'b1;
		do @(negedge clock); while (taken_count == taken_base);
		req_valid = 1'b0;
		req = '0;
		do @(negedge clock); while (done_count == done_base);
		// one more cycle so a stretched or repeated done shows up in the count
		@(negedge clock);
		check_count(test_name[i], "done pulses", 1, done_count - done_base);
		check_count(test_name[i], "ar beats", is_load ? beats : 0, ar_count - ar_base);
		check_count(test_name[i], "aw beats", is_store ? beats : 0, aw_count - aw_base);
		check_count(test_name[i], "w beats", is_store ? beats : 0, w_count - w_base);
		check_count(test_name[i], "register writes", is_load ? 1 : 0, wb_count - wb_base);
		if (is_load) begin
			check_reg(test_name[i], "wb_rd", test_rd[i], last_rd);
			check_word(test_name[i], "load value", test_expect[i], last_wb);
		end
	endtask

	initial begin
		void'($urandom(32));
		clock = 1'b0;
		reset = 1'b1;
		req = '0;
		req_valid = 1'b0;
		arready = 1'b0;
		awready = 1'b0;
		wready = 1'b0;
		r = '0;
		rvalid = 1'b0;
		bid = '0;
		bvalid = 1'b0;
		rd_pending = 1'b0;
		rd_addr = '0;
		rd_id = '0;
		wr_addr = '0;
		wr_id = '0;
		b_pending = 1'b0;
		cur = 0;
		ar_count = 0;
		aw_count = 0;
		w_count = 0;
		taken_count = 0;
		done_count = 0;
		wb_count = 0;
		cycles = 0;
		cycle_limit = 1000;
		load_tests();
		// reset plus a generous budget per access
		cycle_limit = 20 + 40 * test_name.size();

		repeat (10) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
		if (done || wb_en || arvalid || awvalid || wvalid || rready || bready) begin
			fail_now("an output was high right after reset");
		end
		if (!req_allowin) begin
			fail_now("req_allowin was low right after reset");
		end

		for (int i = 0; i < test_name.size(); i++) begin
			run_test(i);
			repeat ($urandom % 3) @(negedge clock);
		end

		repeat (4) @(negedge clock);
		check_count("all", "done pulses", test_name.size(), done_count);
		$display("All tests passed!");
		$finish;
	end

endmodule

// ==== bench/lsu_tests.txt ====
# name  op  addr  store_data  rd  expected_load   (all numbers hex)
# expected_load is 0 for stores and for none
sw_base   sw   00000100 a1b2c3d4 00 00000000
sw_high   sw   00000104 8f7e6d5c 00 00000000
lw_base   lw   00000100 00000000 01 a1b2c3d4
lh_low    lh   00000100 00000000 02 ffffc3d4
lhu_high  lhu  00000102 00000000 03 0000a1b2
lb_byte1  lb   00000101 00000000 04 ffffffc3
lbu_byte3 lbu  00000103 00000000 05 000000a1
lb_pos    lb   00000104 00000000 06 0000005c
lw_x1     lw   00000101 00000000 07 5ca1b2c3
lw_x3     lw   00000103 00000000 08 7e6d5ca1
lh_x3     lh   00000103 00000000 09 00005ca1
sw_dx     sw   00000106 11223344 00 00000000
lw_dx     lw   00000106 00000000 0a 11223344
lh_dx     lh   00000107 00000000 0b 00002233
sh_x      sh   00000113 0000beef 00 00000000
lhu_x     lhu  00000113 00000000 0c 0000beef
lh_x      lh   00000113 00000000 0d ffffbeef
sh_al     sh   00000110 12349a78 00 00000000
sb_mid    sb   00000112 00000055 00 00000000
lw_mix    lw   00000110 00000000 0e ef559a78
sb_top    sb   00000117 000000f0 00 00000000
lb_top    lb   00000117 00000000 0f fffffff0
sw_uart   sw   10000010 cafef00d 00 00000000
lw_uart   lw   10000010 00000000 10 cafef00d
sb_uart   sb   10000ffc 00000041 00 00000000
lbu_uart  lbu  10000ffc 00000000 11 00000041
sw_out    sw   10001000 01020304 00 00000000
lw_out    lw   10001000 00000000 12 01020304
nop       none 00000000 00000000 00 00000000

// ==== filelist.f ====
rtl/lsu_pkg.sv
rtl/lsu_stage.sv
rtl/access_split.sv
rtl/read_channel.sv
rtl/write_channel.sv
rtl/load_merge.sv
rtl/lsu_top.sv
bench/lsu_properties.sv
bench/lsu_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = lsu_tb
FILELIST  = filelist.f
OBJ_DIR   = obj_dir
PASS_MSG  = All tests passed!

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
